/* tinyRvCore.f */
+incdir+include
rtl/rvIsaPkg.sv
rtl/pipePkg.sv
rtl/stageBus.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/tinyRvCore.sv
test/tinyRvCoreTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f tinyRvCore.f --top-module tinyRvCoreTb -o simv \
    && out=$(./obj_dir/simv) \
    && echo "$out" \
    && echo "$out" | grep -q "TEST PASSED" \
    || exit 1

/* include/tbProgram.svh */
/*
 * Test programs and expected retires for the core testbench.
 * Every program ends in a halt; branch offsets are byte offsets.
 * Included inside the testbench module, uses its encoder functions.
 */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

task automatic buildTests();
    // R-type ops with x1=-7 and x2=3
    addTest("aluReg");
    addRetiringWord(iType(-7, 0, 0, 1), 1, 32'hFFFF_FFF9);
    addRetiringWord(iType(3, 0, 0, 2), 2, 32'h0000_0003);
    addRetiringWord(rType(0, 2, 1, 0, 3), 3, 32'hFFFF_FFFC);
    addRetiringWord(rType(32, 1, 2, 0, 4), 4, 32'h0000_000A);
    addRetiringWord(rType(0, 2, 1, 7, 5), 5, 32'h0000_0001);
    addRetiringWord(rType(0, 2, 1, 6, 6), 6, 32'hFFFF_FFFB);
    addRetiringWord(rType(0, 2, 1, 4, 7), 7, 32'hFFFF_FFFA);
    addRetiringWord(rType(0, 2, 1, 2, 8), 8, 32'h0000_0001);
    addRetiringWord(rType(0, 2, 2, 1, 9), 9, 32'h0000_0018);
    addRetiringWord(rType(0, 2, 1, 5, 10), 10, 32'h1FFF_FFFF);
    addRetiringWord(rType(32, 2, 1, 5, 11), 11, 32'hFFFF_FFFF);
    addRetiringWord(luiWord('h12345, 12), 12, 32'h1234_5000);
    addWord(ecallWord);

    // immediate forms
    addTest("aluImm");
    addRetiringWord(luiWord('h80000, 1), 1, 32'h8000_0000);
    addRetiringWord(iType(-1, 1, 0, 2), 2, 32'h7FFF_FFFF);
    addRetiringWord(iType('hF0, 2, 7, 3), 3, 32'h0000_00F0);
    addRetiringWord(iType('h0F, 3, 6, 4), 4, 32'h0000_00FF);
    addRetiringWord(iType(-1, 4, 4, 5), 5, 32'hFFFF_FF00);
    addRetiringWord(iType(0, 1, 2, 6), 6, 32'h0000_0001);
    addRetiringWord(iType(0, 2, 2, 7), 7, 32'h0000_0000);
    addRetiringWord(iType(4, 4, 1, 8), 8, 32'h0000_0FF0);
    addRetiringWord(iType(4, 1, 5, 9), 9, 32'h0800_0000);
    addRetiringWord(iType('h404, 1, 5, 10), 10, 32'hF800_0000);
    addWord(ecallWord);

    // each instruction reads the one before and one write to x0 is dropped
    addTest("depChain");
    addRetiringWord(iType(5, 0, 0, 1), 1, 32'd5);
    addRetiringWord(rType(0, 1, 1, 0, 2), 2, 32'd10);
    addRetiringWord(rType(0, 1, 2, 0, 3), 3, 32'd15);
    addRetiringWord(rType(32, 2, 3, 0, 4), 4, 32'd5);
    addRetiringWord(iType(2, 4, 1, 5), 5, 32'd20);
    addRetiringWord(rType(0, 5, 5, 4, 6), 6, 32'd0);
    addRetiringWord(iType(7, 6, 0, 6), 6, 32'd7);
    addWord(iType(9, 0, 0, 0));
    addRetiringWord(rType(0, 6, 0, 0, 7), 7, 32'd7);
    addWord(ecallWord);

    // taken BEQ and BLT skip two words while BNE and BGE fall through
    addTest("branch");
    addRetiringWord(iType(4, 0, 0, 1), 1, 32'd4);
    addRetiringWord(iType(4, 0, 0, 2), 2, 32'd4);
    addWord(bType(12, 2, 1, 0));
    addWord(iType(1, 0, 0, 3));
    addWord(iType(1, 0, 0, 4));
    addRetiringWord(iType(-2, 0, 0, 5), 5, 32'hFFFF_FFFE);
    addWord(bType(12, 1, 5, 4));
    addWord(iType(1, 0, 0, 6));
    addWord(iType(1, 0, 0, 7));
    addWord(bType(12, 2, 1, 1));
    addRetiringWord(iType(8, 0, 0, 8), 8, 32'd8);
    addWord(bType(12, 1, 5, 5));
    addRetiringWord(iType(9, 0, 0, 9), 9, 32'd9);
    addWord(ecallWord);

    addTest("jal");
    addRetiringWord(iType(1, 0, 0, 1), 1, 32'd1);
    addRetiringWord(jalWord(12, 2), 2, 32'd8);
    addWord(iType(3, 0, 0, 3));
    addWord(iType(4, 0, 0, 4));
    addRetiringWord(iType(1, 2, 0, 5), 5, 32'd9);
    addWord(ecallWord);

    addTest("ecallHalt");
    addRetiringWord(iType(11, 0, 0, 1), 1, 32'd11);
    addWord(ecallWord);
    addWord(iType(22, 0, 0, 2));
    addWord(iType(33, 0, 0, 3));

    // jump to byte 10 which is not word aligned
    addTest("badJump");
    addRetiringWord(iType(1, 0, 0, 1), 1, 32'd1);
    addWord(jalWord(6, 2));
    addWord(iType(3, 0, 0, 3));
    addWord(iType(4, 0, 0, 4));
    addWord(iType(5, 0, 0, 5));

    addTest("illegalOp");
    addRetiringWord(iType(2, 0, 0, 1), 1, 32'd2);
    addWord(32'hFFFF_FFFF);
    addWord(iType(3, 0, 0, 2));
endtask

`endif

/* test/tinyRvCoreTb.sv */
/*
 * Runs each program from the table after a fresh reset and checks the
 * retire stream, then waits for halted. Inputs change 1 unit after CLK rises,
 * outputs are sampled on the falling edge.
 */
module tinyRvCoreTb;

    localparam int maxTests = 10;
    localparam int maxWords = 16;
    localparam int postHaltCycles = 8;

    logic        CLK, arstN, runEn, progWrEn;
    logic [5:0]  progAddr;
    logic [31:0] progData;
    logic        retireValid, halted;
    logic [4:0]  retireRd;
    logic [31:0] retireData;

    string       testName [maxTests];
    logic [31:0] prog     [maxTests][maxWords];
    logic [4:0]  expRd    [maxTests][maxWords];
    logic [31:0] expData  [maxTests][maxWords];
    int          progLen  [maxTests];
    int          expCount [maxTests];
    bit          expHalt  [maxTests];
    int          nTests, passCount, failCount, errors;
    bit          timedOut;

    localparam logic [31:0] ecallWord = 32'h0000_0073;

    tinyRvCore u_tinyRvCore (
        .CLK         (CLK),
        .arstN       (arstN),
        .runEn       (runEn),
        .progWrEn    (progWrEn),
        .progAddr    (progAddr),
        .progData    (progData),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData),
        .halted      (halted)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // RV32I encoders with fields straight from the ISA manual
    function automatic logic [31:0] rType(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] iType(int imm, int rs1, int f3, int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
    endfunction

    function automatic logic [31:0] luiWord(int imm20, int rd);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] bType(int off, int rs2, int rs1, int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jalWord(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6F};
    endfunction

    task automatic addTest(string name);
        testName[nTests] = name;
        progLen[nTests]  = 0;
        expCount[nTests] = 0;
        expHalt[nTests]  = 1'b1;
        nTests++;
    endtask

    task automatic addWord(logic [31:0] word);
        prog[nTests-1][progLen[nTests-1]] = word;
        progLen[nTests-1]++;
    endtask

    // program word that is expected to retire rd with value
    task automatic addRetiringWord(logic [31:0] word, int rd, logic [31:0] value);
        addWord(word);
        expRd[nTests-1][expCount[nTests-1]]   = rd[4:0];
        expData[nTests-1][expCount[nTests-1]] = value;
        expCount[nTests-1]++;
    endtask

    `include "tbProgram.svh"

    task automatic nextDrive();
        @(posedge CLK);
        #1;
    endtask

    task automatic resetAndLoad(int t);
        nextDrive();
        runEn = 1'b0;
        arstN = 1'b0;
        repeat (8) nextDrive();
        arstN = 1'b1;
        for (int w = 0; w < progLen[t]; w++) begin
            nextDrive();
            progWrEn = 1'b1;
            progAddr = 6'(w);
            progData = prog[t][w];
        end
        nextDrive();
        progWrEn = 1'b0;
        runEn    = 1'b1;
    endtask

    task automatic runTest(int t);
        int  cycles;
        int  seen;
        int  limit;
        bit  done;
        errors = 0;
        cycles = 0;
        seen   = 0;
        done   = 1'b0;
        limit  = 4 * progLen[t] + 20;
        while (!done && !timedOut) begin
            @(negedge CLK);
            cycles++;
            if (retireValid) begin
                assert (seen < expCount[t]) else begin
                    $display("%s: unexpected extra retire to x%0d", testName[t], retireRd);
                    errors++;
                end
                if (seen < expCount[t]) begin
                    assert (retireRd == expRd[t][seen] && retireData == expData[t][seen])
                    else begin
                        $display("Mismatch %s retire %0d: expected x%0d=%h, actual x%0d=%h",
                                 testName[t], seen, expRd[t][seen], expData[t][seen],
                                 retireRd, retireData);
                        errors++;
                    end
                end
                seen++;
            end
            if (expHalt[t] ? halted : (seen >= expCount[t])) begin
                done = 1'b1;
            end else if (cycles >= limit) begin
                $display("%s timed out after %0d cycles", testName[t], cycles);
                timedOut = 1'b1;
                errors++;
            end
        end
        // halted must stay up and nothing may retire after it
        if (done) begin
            repeat (postHaltCycles) begin
                @(negedge CLK);
                assert (!retireValid) else begin
                    $display("%s: retire to x%0d after halt", testName[t], retireRd);
                    errors++;
                end
                assert (halted || !expHalt[t]) else begin
                    $display("%s: halted dropped before reset", testName[t]);
                    errors++;
                end
            end
            assert (seen >= expCount[t]) else begin
                $display("%s: only %0d of %0d retires seen", testName[t], seen, expCount[t]);
                errors++;
            end
        end
    endtask

    initial begin
        arstN     = 1'b0;
        runEn     = 1'b0;
        progWrEn  = 1'b0;
        progAddr  = '0;
        progData  = '0;
        nTests    = 0;
        passCount = 0;
        failCount = 0;
        timedOut  = 1'b0;
        buildTests();
        for (int t = 0; t < nTests && !timedOut; t++) begin
            resetAndLoad(t);
            runTest(t);
            if (errors == 0) begin
                $display("test %s passed", testName[t]);
                passCount++;
            end else begin
                $display("test %s failed with %0d errors", testName[t], errors);
                failCount++;
            end
        end
        $display("summary: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && !timedOut) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* rtl/tinyRvCore.sv */
/*
 * Four-stage RV32I subset core with internal instruction memory.
 * Hold runEn low while loading; halted is sticky until reset.
 */
module tinyRvCore (
    input  logic                          CLK,
    input  logic                          arstN,
    input  logic                          runEn,
    input  logic                          progWrEn,
    input  logic [pipePkg::imemAddrW-1:0] progAddr,
    input  logic [rvIsaPkg::xlen-1:0]     progData,
    output logic                          retireValid,
    output logic [rvIsaPkg::regAddrW-1:0] retireRd,
    output logic [rvIsaPkg::xlen-1:0]     retireData,
    output logic                          halted
);

    logic [rvIsaPkg::xlen-1:0]     fdInst, fdPc, target;
    logic [rvIsaPkg::regAddrW-1:0] exRd;
    logic fdValid, stall, redirect, exRegWrEn, exValid;

    idExBus idEx ();
    exWbBus exWb ();

    fetchUnit u_fetchUnit (
        .CLK      (CLK),
        .arstN    (arstN),
        .runEn    (runEn),
        .stall    (stall),
        .redirect (redirect),
        .target   (target),
        .progWrEn (progWrEn),
        .progAddr (progAddr),
        .progData (progData),
        .instWord (fdInst),
        .pc       (fdPc),
        .valid    (fdValid)
    );

    decodeStage u_decodeStage (
        .CLK       (CLK),
        .arstN     (arstN),
        .instWord  (fdInst),
        .pc        (fdPc),
        .valid     (fdValid),
        .squash    (redirect),
        .exRd      (exRd),
        .exRegWrEn (exRegWrEn),
        .exValid   (exValid),
        .stall     (stall),
        .out       (idEx),
        .wb        (exWb)
    );

    executeStage u_executeStage (
        .CLK       (CLK),
        .arstN     (arstN),
        .in        (idEx),
        .out       (exWb),
        .redirect  (redirect),
        .target    (target),
        .exRd      (exRd),
        .exRegWrEn (exRegWrEn),
        .exValid   (exValid)
    );

    // writeback is the execute/writeback register itself
    assign retireValid = exWb.valid && exWb.regWrEn && (exWb.rd != '0);
    assign retireRd    = exWb.rd;
    assign retireData  = exWb.wrData;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            halted <= 1'b0;
        end else if (exWb.valid && exWb.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

/* rtl/executeStage.sv */
/*
 * ALU, branch resolve and the execute/writeback register.
 * Branches compare signed. A taken branch or JAL with a misaligned
 * target halts instead of redirecting and does not write its rd.
 * After any halt passes here, younger instructions become bubbles.
 */
module executeStage (
    input  logic                          CLK,
    input  logic                          arstN,
    idExBus.consumer                      in,
    exWbBus.producer                      out,
    output logic                          redirect,
    output logic [rvIsaPkg::xlen-1:0]     target,
    output logic [rvIsaPkg::regAddrW-1:0] exRd,
    output logic                          exRegWrEn,
    output logic                          exValid
);

    logic [rvIsaPkg::xlen-1:0]   opB, aluResult;
    logic [rvIsaPkg::shamtW-1:0] shamt;
    logic live, haltSeen, condMet, taken, badTarget, trapHalt;

    assign live  = in.valid && !haltSeen;
    assign opB   = in.useImm ? in.imm : in.rs2Data;
    assign shamt = opB[rvIsaPkg::shamtW-1:0];

    always_comb begin
        case (in.aluOp)
            pipePkg::aluAdd:   aluResult = in.rs1Data + opB;
            pipePkg::aluSub:   aluResult = in.rs1Data - opB;
            pipePkg::aluAnd:   aluResult = in.rs1Data & opB;
            pipePkg::aluOr:    aluResult = in.rs1Data | opB;
            pipePkg::aluXor:   aluResult = in.rs1Data ^ opB;
            pipePkg::aluSlt:   aluResult = {{(rvIsaPkg::xlen-1){1'b0}},
                                            $signed(in.rs1Data) < $signed(opB)};
            pipePkg::aluSll:   aluResult = in.rs1Data << shamt;
            pipePkg::aluSrl:   aluResult = in.rs1Data >> shamt;
            pipePkg::aluSra:   aluResult = $signed(in.rs1Data) >>> shamt;
            pipePkg::aluPassB: aluResult = opB;
            default:           aluResult = '0;
        endcase
    end

    always_comb begin
        case (in.branchFunct)
            rvIsaPkg::f3Beq: condMet = (in.rs1Data == in.rs2Data);
            rvIsaPkg::f3Bne: condMet = (in.rs1Data != in.rs2Data);
            rvIsaPkg::f3Blt: condMet = ($signed(in.rs1Data) < $signed(in.rs2Data));
            rvIsaPkg::f3Bge: condMet = ($signed(in.rs1Data) >= $signed(in.rs2Data));
            default:         condMet = 1'b0;
        endcase
    end

    assign target    = in.pc + in.imm;
    assign taken     = live && (in.jump || (in.branch && condMet));
    assign badTarget = |(target & rvIsaPkg::instAlignMask);
    assign redirect  = taken && !badTarget;
    assign trapHalt  = taken && badTarget;

    // hazard view for decode
    assign exRd      = in.rd;
    assign exRegWrEn = in.regWrEn;
    assign exValid   = live;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            out.valid <= 1'b0;
            haltSeen  <= 1'b0;
        end else begin
            out.valid <= live;
            haltSeen  <= haltSeen || (live && (in.halt || trapHalt));
        end
    end

    always_ff @(posedge CLK) begin
        out.rd      <= in.rd;
        out.regWrEn <= in.regWrEn && !trapHalt;
        out.wrData  <= in.isLink ? in.pc + 'd4 : aluResult;
        out.halt    <= in.halt || trapHalt;
    end

    // both younger instructions are killed by fetch and decode
    squashTwo: assert property (@(posedge CLK) disable iff (!arstN)
        (redirect || $past(redirect)) |=> !in.valid);

endmodule

/* rtl/decodeStage.sv */
/*
 * Control decode, immediates, hazard stall and the decode/execute register.
 * No forwarding from execute: a RAW hazard against execute costs one bubble.
 * ECALL or an illegal encoding halts; once a halt leaves decode, nothing
 * younger is issued again until reset.
 */
module decodeStage (
    input  logic                          CLK,
    input  logic                          arstN,
    input  logic [rvIsaPkg::xlen-1:0]     instWord,
    input  logic [rvIsaPkg::xlen-1:0]     pc,
    input  logic                          valid,
    input  logic                          squash,
    input  logic [rvIsaPkg::regAddrW-1:0] exRd,
    input  logic                          exRegWrEn,
    input  logic                          exValid,
    output logic                          stall,
    idExBus.producer                      out,
    exWbBus.sink                          wb
);

    rvIsaPkg::opcodeE              op;
    logic [rvIsaPkg::regAddrW-1:0] rd, rs1, rs2;
    logic [rvIsaPkg::funct3W-1:0]  funct3;
    logic                          altOp;
    logic [rvIsaPkg::xlen-1:0]     rs1Data, rs2Data;
    logic [rvIsaPkg::xlen-1:0]     immI, immB, immU, immJ, imm;
    pipePkg::aluOpE                aluOp;
    logic regWrEn, useImm, isLink, branch, jump;
    logic rs1Used, rs2Used, isSystem, illegal;
    logic decHalt, hazard, haltPending;

    assign op     = rvIsaPkg::opcodeE'(instWord[6:0]);
    assign rd     = instWord[11:7];
    assign funct3 = instWord[14:12];
    assign rs1    = instWord[19:15];
    assign rs2    = instWord[24:20];
    assign altOp  = (instWord[31:25] == rvIsaPkg::funct7Alt);

    assign immI = {{20{instWord[31]}}, instWord[31:20]};
    assign immB = {{20{instWord[31]}}, instWord[7], instWord[30:25], instWord[11:8], 1'b0};
    assign immU = {instWord[31:12], 12'b0};
    assign immJ = {{12{instWord[31]}}, instWord[19:12], instWord[20], instWord[30:21], 1'b0};

    regFile u_regFile (
        .CLK     (CLK),
        .arstN   (arstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wb      (wb)
    );

    always_comb begin
        aluOp    = pipePkg::aluAdd;
        imm      = immI;
        regWrEn  = 1'b0;
        useImm   = 1'b0;
        isLink   = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        rs1Used  = 1'b0;
        rs2Used  = 1'b0;
        isSystem = 1'b0;
        illegal  = 1'b0;
        case (op)
            rvIsaPkg::opCompute, rvIsaPkg::opICompute: begin
                regWrEn = 1'b1;
                rs1Used = 1'b1;
                rs2Used = (op == rvIsaPkg::opCompute);
                useImm  = (op == rvIsaPkg::opICompute);
                case (funct3)
                    // funct7 is immediate bits for ADDI
                    rvIsaPkg::f3AddSub: aluOp = (altOp && !useImm) ? pipePkg::aluSub
                                                                   : pipePkg::aluAdd;
                    rvIsaPkg::f3Sll:    aluOp = pipePkg::aluSll;
                    rvIsaPkg::f3Slt:    aluOp = pipePkg::aluSlt;
                    rvIsaPkg::f3Xor:    aluOp = pipePkg::aluXor;
                    rvIsaPkg::f3SrlSra: aluOp = altOp ? pipePkg::aluSra : pipePkg::aluSrl;
                    rvIsaPkg::f3Or:     aluOp = pipePkg::aluOr;
                    rvIsaPkg::f3And:    aluOp = pipePkg::aluAnd;
                    default:            illegal = 1'b1;
                endcase
            end
            rvIsaPkg::opBranch: begin
                imm     = immB;
                branch  = 1'b1;
                rs1Used = 1'b1;
                rs2Used = 1'b1;
                // unsigned branches are not supported
                illegal = !(funct3 inside {rvIsaPkg::f3Beq, rvIsaPkg::f3Bne,
                                           rvIsaPkg::f3Blt, rvIsaPkg::f3Bge});
            end
            rvIsaPkg::opJal: begin
                imm     = immJ;
                regWrEn = 1'b1;
                jump    = 1'b1;
                isLink  = 1'b1;
            end
            rvIsaPkg::opLui: begin
                imm     = immU;
                regWrEn = 1'b1;
                useImm  = 1'b1;
                aluOp   = pipePkg::aluPassB;
            end
            rvIsaPkg::opSystem: isSystem = 1'b1;
            default:            illegal  = 1'b1;
        endcase
    end

    assign decHalt = valid && (isSystem || illegal);

    // RAW hazard against execute ignores x0
    assign hazard = valid && !squash && exValid && exRegWrEn && (exRd != '0) &&
                    ((rs1Used && rs1 == exRd) || (rs2Used && rs2 == exRd));

    // a halt also freezes fetch for good
    assign stall = hazard || (decHalt && !squash) || haltPending;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            out.valid   <= 1'b0;
            haltPending <= 1'b0;
        end else begin
            out.valid   <= valid && !squash && !hazard && !haltPending;
            // pending only once the halting word has issued to execute
            haltPending <= haltPending || (decHalt && !squash && !hazard);
        end
    end

    always_ff @(posedge CLK) begin
        out.pc          <= pc;
        out.rs1Data     <= rs1Data;
        out.rs2Data     <= rs2Data;
        out.imm         <= imm;
        out.rd          <= rd;
        out.regWrEn     <= regWrEn && !illegal;
        out.aluOp       <= aluOp;
        out.useImm      <= useImm;
        out.isLink      <= isLink;
        out.branch      <= branch;
        out.branchFunct <= funct3;
        out.jump        <= jump;
        out.halt        <= decHalt || haltPending;
    end

    // execute must never redirect once a halt has left decode
    noStallOnSquash: assert property (@(posedge CLK) disable iff (!arstN)
        valid |-> !(stall && squash));

endmodule

/* rtl/regFile.sv */
/*
 * 32-entry register file, x0 reads as zero and has no storage.
 * A writeback in the same cycle is forwarded to the read ports.
 */
module regFile (
    input  logic                          CLK,
    input  logic                          arstN,
    input  logic [rvIsaPkg::regAddrW-1:0] rs1,
    input  logic [rvIsaPkg::regAddrW-1:0] rs2,
    output logic [rvIsaPkg::xlen-1:0]     rs1Data,
    output logic [rvIsaPkg::xlen-1:0]     rs2Data,
    exWbBus.sink                          wb
);

    logic [rvIsaPkg::xlen-1:0] regs [1:31];
    logic                      wrEn;

    assign wrEn = wb.valid && wb.regWrEn && (wb.rd != '0);

    always_ff @(posedge CLK) begin
        if (wrEn) begin
            regs[wb.rd] <= wb.wrData;
        end
    end

    // write-through replaces forwarding from writeback
    assign rs1Data = (rs1 == '0)              ? '0 :
                     (wrEn && wb.rd == rs1)   ? wb.wrData : regs[rs1];
    assign rs2Data = (rs2 == '0)              ? '0 :
                     (wrEn && wb.rd == rs2)   ? wb.wrData : regs[rs2];

    // a register written last cycle reads back the same value from storage
    writeReadsBack: assert property (@(posedge CLK) disable iff (!arstN)
        ($past(wrEn) && rs1 == $past(wb.rd) && !(wrEn && wb.rd == rs1)) |->
            (rs1Data == $past(wb.wrData)));

endmodule

/* rtl/fetchUnit.sv */
/*
 * PC, instruction memory and the fetch/decode register.
 * Load the program with progWrEn only while runEn is low.
 * Redirect beats stall; stall (hazard or halt) freezes everything here.
 */
module fetchUnit (
    input  logic                          CLK,
    input  logic                          arstN,
    input  logic                          runEn,
    input  logic                          stall,
    input  logic                          redirect,
    input  logic [rvIsaPkg::xlen-1:0]     target,
    input  logic                          progWrEn,
    input  logic [pipePkg::imemAddrW-1:0] progAddr,
    input  logic [rvIsaPkg::xlen-1:0]     progData,
    output logic [rvIsaPkg::xlen-1:0]     instWord,
    output logic [rvIsaPkg::xlen-1:0]     pc,
    output logic                          valid
);

    logic [rvIsaPkg::xlen-1:0] imem [pipePkg::imemDepth];
    logic [rvIsaPkg::xlen-1:0] fetchPc;
    logic                      advance;

    assign advance = runEn && !stall && !redirect;

    // program load port
    always_ff @(posedge CLK) begin
        if (progWrEn) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            fetchPc <= pipePkg::resetPc;
            valid   <= 1'b0;
        end else if (redirect) begin
            // the word in decode is on the wrong path
            fetchPc <= target;
            valid   <= 1'b0;
        end else if (!runEn) begin
            valid <= 1'b0;
        end else if (!stall) begin
            fetchPc <= fetchPc + 'd4;
            valid   <= 1'b1;
        end
    end

    // synchronous read lands directly in the fetch/decode register
    always_ff @(posedge CLK) begin
        if (advance) begin
            instWord <= imem[fetchPc[pipePkg::imemAddrW+1:2]];
            pc       <= fetchPc;
        end
    end

    progWhileIdle: assert property (@(posedge CLK) disable iff (!arstN)
        progWrEn |-> !runEn);

endmodule

/* rtl/stageBus.sv */
/*
 * Stage boundary buses. idExBus is the decode/execute register,
 * exWbBus the execute/writeback register. Payload is only
 * meaningful while valid is high.
 */
interface idExBus;
    logic                            valid;
    logic [rvIsaPkg::xlen-1:0]       pc;
    logic [rvIsaPkg::xlen-1:0]       rs1Data;
    logic [rvIsaPkg::xlen-1:0]       rs2Data;
    logic [rvIsaPkg::xlen-1:0]       imm;
    logic [rvIsaPkg::regAddrW-1:0]   rd;
    logic                            regWrEn;
    pipePkg::aluOpE                  aluOp;
    logic                            useImm;
    logic                            isLink;
    logic                            branch;
    logic [rvIsaPkg::funct3W-1:0]    branchFunct;
    logic                            jump;
    logic                            halt;

    modport producer (
        output valid, pc, rs1Data, rs2Data, imm, rd, regWrEn,
               aluOp, useImm, isLink, branch, branchFunct, jump, halt
    );
    modport consumer (
        input valid, pc, rs1Data, rs2Data, imm, rd, regWrEn,
              aluOp, useImm, isLink, branch, branchFunct, jump, halt
    );
endinterface

interface exWbBus;
    logic                            valid;
    logic [rvIsaPkg::regAddrW-1:0]   rd;
    logic                            regWrEn;
    logic [rvIsaPkg::xlen-1:0]       wrData;
    logic                            halt;

    modport producer (output valid, rd, regWrEn, wrData, halt);
    modport sink     (input valid, rd, regWrEn, wrData, halt);
endinterface

/* rtl/pipePkg.sv */
/*
 * Pipeline-level types and sizes.
 * Instruction memory is small and word addressed; the PC wraps inside it.
 */
package pipePkg;

    // alu operation chosen in decode
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluSra,
        aluPassB
    } aluOpE;

    localparam int imemDepth = 64;
    localparam int imemAddrW = $clog2(imemDepth);

    localparam logic [rvIsaPkg::xlen-1:0] resetPc = '0;

endpackage

/* rtl/rvIsaPkg.sv */
/*
 * RV32I encodings for the subset this core runs.
 * JALR, AUIPC, loads, stores and unsigned compares are not decoded.
 * Any opcode outside opcodeE is treated as illegal and halts.
 */
package rvIsaPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int funct3W  = 3;
    localparam int funct7W  = 7;
    localparam int shamtW   = 5;

    // major opcodes in bits [6:0] of the instruction
    typedef enum logic [6:0] {
        opCompute  = 7'b0110011,
        opICompute = 7'b0010011,
        opBranch   = 7'b1100011,
        opJal      = 7'b1101111,
        opLui      = 7'b0110111,
        opSystem   = 7'b1110011
    } opcodeE;

    // alu funct3
    localparam logic [funct3W-1:0] f3AddSub = 3'b000;
    localparam logic [funct3W-1:0] f3Sll    = 3'b001;
    localparam logic [funct3W-1:0] f3Slt    = 3'b010;
    localparam logic [funct3W-1:0] f3Xor    = 3'b100;
    localparam logic [funct3W-1:0] f3SrlSra = 3'b101;
    localparam logic [funct3W-1:0] f3Or     = 3'b110;
    localparam logic [funct3W-1:0] f3And    = 3'b111;

    // branch funct3 for the signed compares only
    localparam logic [funct3W-1:0] f3Beq = 3'b000;
    localparam logic [funct3W-1:0] f3Bne = 3'b001;
    localparam logic [funct3W-1:0] f3Blt = 3'b100;
    localparam logic [funct3W-1:0] f3Bge = 3'b101;

    // selects SUB / SRA / SRAI
    localparam logic [funct7W-1:0] funct7Alt = 7'b0100000;

    // instruction addresses are word aligned
    localparam logic [xlen-1:0] instAlignMask = 32'h0000_0003;

endpackage
